// ==== rtl/flitPkg.sv ====
package flitPkg;

  // ********************
  // Flit format
  // ********************
  localparam int NumPorts     = 5;
  localparam int PayloadWidth = 16;
  localparam int LengthWidth  = 12;

  typedef enum logic [2:0] {
    FlitHead = 3'd1,
    FlitBody = 3'd2,
    FlitTail = 3'd3
  } flitKind;

  // Index of each input side, also the grant encoding
  typedef enum logic [2:0] {
    PortL = 3'd0,
    PortN = 3'd1,
    PortE = 3'd2,
    PortW = 3'd3,
    PortS = 3'd4
  } portId;

  typedef struct packed {
    flitKind                 kind;
    logic [LengthWidth-1:0]  length;   // Grant limit in cycles, head flits only
    logic [PayloadWidth-1:0] payload;
  } flitT;

  // Outbound word carries the source side along
  typedef struct packed {
    portId source;
    flitT  flit;
  } linkFlitT;

endpackage

// ==== rtl/arbPkg.sv ====
package arbPkg;

  localparam int QueueDepth = 4;
  localparam int PtrWidth   = $clog2(QueueDepth);
  localparam int CountWidth = flitPkg::LengthWidth;  // Compared against head length

  // Grant states share the portId values, idle sits outside that range
  typedef enum logic [2:0] {
    GrantL = 3'd0,
    GrantN = 3'd1,
    GrantE = 3'd2,
    GrantW = 3'd3,
    GrantS = 3'd4,
    Idle   = 3'd7
  } arbState;

endpackage

// ==== rtl/flitQueue.sv ====
module flitQueue (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             pushValid,
  input  flitPkg::flitT                    pushFlit,
  output logic                             pushReady,
  input  logic                             pop,
  output logic                             req,
  output flitPkg::flitT                    headFlit,
  output logic [flitPkg::LengthWidth-1:0]  limit
);
  import flitPkg::*;
  import arbPkg::*;

  flitT                   mem [QueueDepth];
  logic [PtrWidth-1:0]    rdPtr;
  logic [PtrWidth-1:0]    wrPtr;
  logic [PtrWidth:0]      count;
  logic [LengthWidth-1:0] heldLimit;
  logic                   pushEn;
  logic                   popEn;
  logic                   headAtFront;

  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pushReady   = (count != (PtrWidth + 1)'(QueueDepth));
  assign req         = (count != '0);
  assign pushEn      = pushValid && pushReady;
  assign popEn       = pop && req;
  assign headFlit    = mem[rdPtr];
  assign headAtFront = req && (headFlit.kind == FlitHead);

  // A fresh head applies at once, body flits keep the packet's limit
  assign limit = headAtFront ? headFlit.length : heldLimit;

  always_ff @(posedge clk)
  begin
    if (pushEn)
      mem[wrPtr] <= pushFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr     <= '0;
      wrPtr     <= '0;
      count     <= '0;
      heldLimit <= '0;
    end
    else
    begin
      if (pushEn)
        wrPtr <= nextPtr(wrPtr);
      if (popEn)
        rdPtr <= nextPtr(rdPtr);
      if (pushEn && !popEn)
        count <= count + 1'b1;
      else if (popEn && !pushEn)
        count <= count - 1'b1;
      if (headAtFront)
        heldLimit <= headFlit.length;
    end
  end

endmodule

// ==== rtl/grantTimer.sv ====
module grantTimer (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            run,
  input  logic [arbPkg::CountWidth-1:0]   limit,
  output logic                            expired
);
  import arbPkg::*;

  logic [CountWidth-1:0] count;

  // Counts cycles of an active grant, cleared as soon as run drops
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (!run)
      count <= '0;
    else
      count <= count + 1'b1;
  end

  assign expired = (count == limit);

endmodule

// ==== rtl/portArbiter.sv ====
module portArbiter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [flitPkg::NumPorts-1:0]  req,
  input  logic [flitPkg::NumPorts-1:0]  expired,
  output logic [flitPkg::NumPorts-1:0]  run,
  output arbPkg::arbState               grant
);
  import flitPkg::*;
  import arbPkg::*;

  arbState state;
  arbState nextState;

  // ********************
  // State register
  // ********************
  always_ff @(posedge clk)
  begin
    if (rst)
      state <= Idle;
    else
      state <= nextState;
  end

  assign grant = state;

  // ********************
  // Next grant
  // ********************
  always_comb
  begin : nextGrant
    int cur;
    int p;
    nextState = Idle;
    run       = '0;
    cur       = int'(state);
    p         = 0;
    if (state == Idle)
    begin
      // Fixed priority L, N, E, W, S, lowest index wins
      for (int i = NumPorts - 1; i >= 0; i--)
      begin
        if (req[i])
          nextState = arbState'(i);
      end
    end
    else if (cur < NumPorts)
    begin
      if (req[cur] && !expired[cur])
      begin
        nextState = state;  // Hold and keep the timer going
        run[cur]  = 1'b1;
      end
      else
      begin
        // Nearest requester after the current port, current one excluded
        for (int k = NumPorts - 1; k >= 1; k--)
        begin
          p = cur + k;
          if (p >= NumPorts)
            p = p - NumPorts;
          if (req[p])
            nextState = arbState'(p);
        end
      end
    end
  end

endmodule

// ==== rtl/linkMaster.sv ====
module linkMaster (
  input  logic                          clk,
  input  logic                          rst,
  input  arbPkg::arbState               grant,
  input  flitPkg::flitT                 heads [flitPkg::NumPorts],
  input  logic [flitPkg::NumPorts-1:0]  req,
  output logic [flitPkg::NumPorts-1:0]  pop,
  output logic                          wbCyc,
  output logic                          wbStb,
  output flitPkg::linkFlitT             wbDat,
  input  logic                          wbAck
);
  import flitPkg::*;
  import arbPkg::*;

  linkFlitT selFlit;
  logic     granted;
  logic     load;
  logic     full;

  // ********************
  // Granted head select
  // ********************
  always_comb
  begin
    selFlit = '0;
    granted = 1'b0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (grant == arbState'(p))
      begin
        selFlit.source = portId'(p);
        selFlit.flit   = heads[p];
        granted        = req[p];
      end
    end
  end

  // Empty register, or the word in it completes this edge
  assign load = granted && (!full || wbAck);

  always_comb
  begin
    for (int p = 0; p < NumPorts; p++)
      pop[p] = load && (grant == arbState'(p));
  end

  // ********************
  // Holding register
  // ********************
  always_ff @(posedge clk)
  begin
    if (rst)
      full <= 1'b0;
    else if (load)
      full <= 1'b1;
    else if (wbAck)
      full <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load)
      wbDat <= selFlit;
  end

  assign wbCyc = full;
  assign wbStb = full;  // Single beat cycles, strobe follows cycle

endmodule

// ==== rtl/routerOutput.sv ====
module routerOutput (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [flitPkg::NumPorts-1:0]  pushValid,
  input  flitPkg::flitT                 pushFlit [flitPkg::NumPorts],
  output logic [flitPkg::NumPorts-1:0]  pushReady,
  output logic                          wbCyc,
  output logic                          wbStb,
  output flitPkg::linkFlitT             wbDat,
  input  logic                          wbAck
);
  import flitPkg::*;
  import arbPkg::*;

  logic [NumPorts-1:0]    req;
  logic [NumPorts-1:0]    pop;
  logic [NumPorts-1:0]    run;
  logic [NumPorts-1:0]    expired;
  logic [LengthWidth-1:0] limits [NumPorts];
  flitT                   heads [NumPorts];
  arbState                grant;

  // One queue and one timer per input side
  for (genvar p = 0; p < NumPorts; p++)
  begin : gPort
    flitQueue queue_i (
      .clk       (clk),
      .rst       (rst),
      .pushValid (pushValid[p]),
      .pushFlit  (pushFlit[p]),
      .pushReady (pushReady[p]),
      .pop       (pop[p]),
      .req       (req[p]),
      .headFlit  (heads[p]),
      .limit     (limits[p])
    );

    grantTimer timer_i (
      .clk     (clk),
      .rst     (rst),
      .run     (run[p]),
      .limit   (limits[p]),
      .expired (expired[p])
    );
  end

  portArbiter arbiter_i (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .expired (expired),
    .run     (run),
    .grant   (grant)
  );

  linkMaster link_i (
    .clk   (clk),
    .rst   (rst),
    .grant (grant),
    .heads (heads),
    .req   (req),
    .pop   (pop),
    .wbCyc (wbCyc),
    .wbStb (wbStb),
    .wbDat (wbDat),
    .wbAck (wbAck)
  );

endmodule

// ==== sim/routerOutput_checker.sv ====
module routerOutput_checker (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [flitPkg::NumPorts-1:0]  pushValid,
  input  logic [flitPkg::NumPorts-1:0]  pushReady,
  input  flitPkg::flitT                 pushFlit [flitPkg::NumPorts],
  input  logic [flitPkg::NumPorts-1:0]  req,
  input  logic                          wbCyc,
  input  logic                          wbStb,
  input  flitPkg::linkFlitT             wbDat,
  input  logic                          wbAck
);
  import flitPkg::*;

  logic [PayloadWidth-1:0] expSeq [NumPorts];   // Next payload due per source
  logic [LengthWidth-1:0]  headLen [NumPorts];
  logic                    anyPush;
  logic                    acked;
  logic                    othersReq;
  portId                   runSrc;
  int                      runLen;
  int                      errCount = 0;

  assign acked     = wbStb && wbAck;
  assign othersReq = |(req & ~(NumPorts'(1) << runSrc));

  // ********************
  // Reference state
  // ********************
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      anyPush <= 1'b0;
      runSrc  <= PortL;
      runLen  <= 0;
      for (int p = 0; p < NumPorts; p++)
      begin
        expSeq[p]  <= '0;
        headLen[p] <= '0;
      end
    end
    else
    begin
      for (int p = 0; p < NumPorts; p++)
      begin
        if (pushValid[p] && pushReady[p])
        begin
          anyPush <= 1'b1;
          if (pushFlit[p].kind == FlitHead)
            headLen[p] <= pushFlit[p].length;
        end
      end
      if (acked)
      begin
        expSeq[wbDat.source] <= expSeq[wbDat.source] + 1'b1;
        runSrc <= wbDat.source;
        runLen <= (wbDat.source == runSrc && othersReq) ? runLen + 1 : 1;
      end
      else if (!othersReq || wbStb)
        runLen <= 0;  // Uncontended or stalled, run starts over
    end
  end

  // ********************
  // Link properties
  // ********************
  quietLink: assert property (@(posedge clk) disable iff (rst)
    !anyPush |-> !wbCyc && !wbStb)
  else
  begin
    $error("Link went active although no flit was ever pushed");
    errCount++;
  end

  // An empty queue is never full
  readyWhenEmpty: assert property (@(posedge clk) disable iff (rst)
    &(pushReady | req))
  else
  begin
    $error("An empty input queue refused pushes");
    errCount++;
  end

  holdData: assert property (@(posedge clk) disable iff (rst)
    wbStb && !wbAck |=> wbStb && $stable(wbDat))
  else
  begin
    $error("FAILED t=%0t wbDat got %h expected %h held", $time,
           $sampled(wbDat), $past(wbDat));
    errCount++;
  end

  inOrder: assert property (@(posedge clk) disable iff (rst)
    acked |-> wbDat.flit.payload == expSeq[wbDat.source])
  else
  begin
    $error("FAILED t=%0t wbDat.flit.payload got %0d expected %0d", $time,
           $sampled(wbDat.flit.payload), $sampled(expSeq[wbDat.source]));
    errCount++;
  end

  // Contended run from one source stays within its head limit plus 2
  grantLimit: assert property (@(posedge clk) disable iff (rst)
    acked && wbDat.source == runSrc |-> runLen + 1 <= int'(headLen[runSrc]) + 2)
  else
  begin
    $error("FAILED t=%0t run length of source %0d got %0d limit %0d", $time,
           $sampled(runSrc), $sampled(runLen) + 1, $sampled(headLen[runSrc]) + 2);
    errCount++;
  end

endmodule

bind routerOutput routerOutput_checker checker_i (
  .clk       (clk),
  .rst       (rst),
  .pushValid (pushValid),
  .pushReady (pushReady),
  .pushFlit  (pushFlit),
  .req       (req),
  .wbCyc     (wbCyc),
  .wbStb     (wbStb),
  .wbDat     (wbDat),
  .wbAck     (wbAck)
);

// ==== sim/routerOutput_tb.sv ====
module routerOutput_tb;
  import flitPkg::*;

  localparam int ClkPeriod  = 20;
  localparam int PktFlits   = 4;
  localparam int TotalFlits = 520;  // Upper bound on offered flits over all tests

  logic                clk = 1'b0;
  logic                rst;
  logic [NumPorts-1:0] pushValid;
  logic [NumPorts-1:0] pushReady;
  flitT                pushFlit [NumPorts];
  logic                wbCyc;
  logic                wbStb;
  linkFlitT            wbDat;
  logic                wbAck;

  int   seed      = 94765;
  int   lens [NumPorts] = '{1, 6, 2, 5, 1};  // Short and long grant limits
  int   seq [NumPorts];
  int   accepted  = 0;
  int   delivered = 0;
  int   errors    = 0;
  int   errMark   = 0;
  int   testsRun  = 0;
  logic ackHigh   = 1'b0;

  routerOutput dut_i (.*);

  always #(ClkPeriod / 2) clk = ~clk;

  always @(posedge clk)
  begin
    if (wbStb && wbAck)
      delivered++;
  end

  function automatic int totalErrors();
    return errors + dut_i.checker_i.errCount;
  endfunction

  // ********************
  // Stimulus
  // ********************
  task automatic driveCycle(input logic [NumPorts-1:0] offer);
    @(negedge clk);
    wbAck = ackHigh ? 1'b1 : 1'($random(seed));
    for (int p = 0; p < NumPorts; p++)
    begin
      pushValid[p]        = offer[p];
      pushFlit[p].payload = PayloadWidth'(seq[p]);
      pushFlit[p].length  = LengthWidth'(lens[p]);
      pushFlit[p].kind    = (seq[p] % PktFlits == 0) ? FlitHead :
                            (seq[p] % PktFlits == PktFlits - 1) ? FlitTail : FlitBody;
      if (offer[p] && pushReady[p])  // Ready is stable until the next rising edge
      begin
        seq[p]++;
        accepted++;
      end
    end
  endtask

  task automatic finishTest(input string name);
    int waitCycles;
    waitCycles = 0;
    while (delivered != accepted && waitCycles < 400)
    begin
      driveCycle('0);
      waitCycles++;
    end
    if (delivered != accepted)
    begin
      $display("Test %s: link stopped delivering with flits still queued", name);
      errors++;
    end
    repeat (5) driveCycle('0);
    assert (delivered == accepted)
    else
    begin
      $display("FAILED t=%0t delivered got %0d expected %0d", $time, delivered, accepted);
      errors++;
    end
    testsRun++;
    $display("Test %0d %s: %0d errors", testsRun, name, totalErrors() - errMark);
    errMark = totalErrors();
  endtask

  initial
  begin : watchdog
    #(TotalFlits * 40 * ClkPeriod);
    $display("Timeout: run did not complete within %0d cycles", TotalFlits * 40);
    $display("Verification failed");
    $finish;
  end

  initial
  begin : main
    rst       = 1'b1;
    wbAck     = 1'b0;
    pushValid = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      pushFlit[p] = '0;
      seq[p]      = 0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    repeat (20) driveCycle('0);
    finishTest("idle link");

    repeat (8) driveCycle(5'b01000);
    finishTest("back-pressure on one port");

    repeat (40) driveCycle(NumPorts'($random(seed)));
    finishTest("random traffic on all ports");

    ackHigh = 1'b1;   // Full-rate link so grant limits bound each run
    repeat (60) driveCycle('1);
    finishTest("grant limits under contention");

    repeat (12) driveCycle(5'b10000);
    finishTest("single port through timer expiry");

    $display("%0d tests run, %0d errors", testsRun, totalErrors());
    if (totalErrors() == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== flist.f ====
rtl/flitPkg.sv
rtl/arbPkg.sv
rtl/flitQueue.sv
rtl/grantTimer.sv
rtl/portArbiter.sv
rtl/linkMaster.sv
rtl/routerOutput.sv
sim/routerOutput_checker.sv
sim/routerOutput_tb.sv

// ==== Makefile ====
TOP = routerOutput_tb

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@! grep -q "Verification failed" sim.log
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
